// ==== flist.f ====
hw/mul_pkg.sv
hw/compressor_42.sv
hw/booth_radix4.sv
hw/wallace_tree.sv
hw/mul_decode.sv
hw/mul_execute.sv
hw/mul_result.sv
hw/mul_unit.sv
verification/clock_gen.sv
verification/mul_unit_checker.sv
verification/mul_unit_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := mul_unit_tb
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := +verilator+error+limit+1000
FAIL_MSG   := ERRORS FOUND
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/mul_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit_tb import mul_pkg::*; ();

    localparam int unsigned SEED = 32'h9af4b8e2;
    localparam int LATENCY       = 3;
    localparam int RESET_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 20;
    localparam int RANDOM_OPS    = 300;
    localparam int TABLE_LEN     = 16;

    typedef struct packed {
        mul_op_t         op;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] expected;
    } vector_t;

    // hand-worked products with MULHSU and MULH rows on shared operands
    vector_t vectors [TABLE_LEN] = '{
        '{MUL,    32'h00000000, 32'hffffffff, 32'h00000000},
        '{MUL,    32'hffffffff, 32'hffffffff, 32'h00000001},
        '{MUL,    32'h80000000, 32'h7fffffff, 32'h80000000},
        '{MUL,    32'h7fffffff, 32'h7fffffff, 32'h00000001},
        '{MULH,   32'hffffffff, 32'hffffffff, 32'h00000000},
        '{MULH,   32'h80000000, 32'h80000000, 32'h40000000},
        '{MULH,   32'h80000000, 32'h7fffffff, 32'hc0000000},
        '{MULH,   32'hffffffff, 32'h00000001, 32'hffffffff},
        '{MULHSU, 32'hffffffff, 32'hffffffff, 32'hffffffff},
        '{MULHSU, 32'h80000000, 32'h80000000, 32'hc0000000},
        '{MULHSU, 32'h7fffffff, 32'hffffffff, 32'h7ffffffe},
        '{MULHSU, 32'h00000001, 32'h80000000, 32'h00000000},
        '{MULHU,  32'hffffffff, 32'hffffffff, 32'hfffffffe},
        '{MULHU,  32'h80000000, 32'h80000000, 32'h40000000},
        '{MULHU,  32'h7fffffff, 32'h80000000, 32'h3fffffff},
        '{MULHU,  32'h00000000, 32'h7fffffff, 32'h00000000}
    };

    logic [XLEN-1:0] corners [5] = '{
        32'h00000000, 32'h00000001, 32'hffffffff, 32'h80000000, 32'h7fffffff
    };

    logic            clock;
    logic            power_on_reset;
    logic            mid_reset;
    logic            reset;
    logic            in_valid;
    mul_op_t         op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            out_valid;
    logic [XLEN-1:0] result;

    logic [XLEN-1:0] exp_q [$];
    string           name_q [$];
    int              cycle_q [$];
    int              cycle_count = 0;
    int              expected_pulses = 0;
    int              out_count = 0;
    int              errors = 0;
    int              timeouts = 0;

    assign reset = power_on_reset | mid_reset;

    clock_gen i_clock_gen (
        .clock (clock),
        .reset (power_on_reset)
    );

    mul_unit i_mul_unit (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .op        (op),
        .rs1       (rs1),
        .rs2       (rs2),
        .out_valid (out_valid),
        .result    (result)
    );

    // operands widened by the sign the operation implies
    function automatic logic [XLEN-1:0] model_result(input mul_op_t o,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic              a_sign;
        logic              b_sign;
        logic [PROD_W-1:0] a_ext;
        logic [PROD_W-1:0] b_ext;
        logic [PROD_W-1:0] prod;
        a_sign = (o == MULH || o == MULHSU) && a[XLEN-1];
        b_sign = (o == MULH) && b[XLEN-1];
        a_ext = {{XLEN{a_sign}}, a};
        b_ext = {{XLEN{b_sign}}, b};
        prod = a_ext * b_ext;
        if (o == MUL) begin
            return prod[XLEN-1:0];
        end
        return prod[PROD_W-1:XLEN];
    endfunction

    task automatic check_result(input string name, input logic [XLEN-1:0] expected,
                                input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic issue_op(input string name, input mul_op_t o, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input logic [XLEN-1:0] expected);
        @(negedge clock);
        in_valid = 1'b1;
        op = o;
        rs1 = a;
        rs2 = b;
        exp_q.push_back(expected);
        name_q.push_back(name);
        cycle_q.push_back(cycle_count);
        expected_pulses++;
    endtask

    task automatic idle_cycle();
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        idle_cycle();
        while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: %0d results never came out", exp_q.size());
            timeouts++;
        end
    endtask

    always @(posedge clock) begin
        cycle_count++;
    end

    // pops one expected result per out_valid pulse
    always @(negedge clock) begin : monitor
        string name;
        int    issue_cycle;
        if (out_valid) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("out_valid went high with no operation in flight");
                errors++;
            end else begin
                name = name_q.pop_front();
                issue_cycle = cycle_q.pop_front();
                check_result(name, exp_q.pop_front(), result);
                check_count({name, " latency"}, LATENCY, cycle_count - issue_cycle);
            end
        end
    end

    initial begin
        int              waited;
        logic [1:0]      op_bits;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        mul_op_t         o;
        int              assert_errors;
        in_valid = 1'b0;
        op = MUL;
        rs1 = '0;
        rs2 = '0;
        mid_reset = 1'b0;
        void'($urandom(SEED));

        waited = 0;
        @(negedge clock);
        while (reset && waited < RESET_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (reset) begin
            $display("timeout: power-on reset was never released");
            timeouts++;
        end

        for (int i = 0; i < TABLE_LEN; i++) begin
            check_result($sformatf("model_%0d", i), vectors[i].expected,
                         model_result(vectors[i].op, vectors[i].rs1, vectors[i].rs2));
            issue_op($sformatf("table_%0d", i), vectors[i].op, vectors[i].rs1,
                     vectors[i].rs2, vectors[i].expected);
        end

        // every op on every corner pair back to back
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    o = mul_op_t'(2'(k));
                    issue_op($sformatf("corner_%0d_%0d_%0d", k, i, j), o, corners[i],
                             corners[j], model_result(o, corners[i], corners[j]));
                end
            end
        end
        wait_drain();

        for (int n = 0; n < RANDOM_OPS; n++) begin
            if ($urandom_range(3, 0) == 0) begin
                idle_cycle();
            end else begin
                op_bits = 2'($urandom_range(3, 0));
                o = mul_op_t'(op_bits);
                a = $urandom;
                b = $urandom;
                issue_op($sformatf("random_%0d", n), o, a, b, model_result(o, a, b));
            end
        end
        wait_drain();

        // reset lands while both operations are still in the pipeline
        issue_op("dropped_a", MULH, 32'h12345678, 32'h9abcdef0, 32'h0);
        issue_op("dropped_b", MULHU, 32'hdeadbeef, 32'h00c0ffee, 32'h0);
        @(negedge clock);
        in_valid = 1'b0;
        mid_reset = 1'b1;
        expected_pulses -= exp_q.size();
        exp_q.delete();
        name_q.delete();
        cycle_q.delete();
        @(negedge clock);
        mid_reset = 1'b0;
        repeat (6) idle_cycle();

        issue_op("after_reset_0", MUL, 32'h00000007, 32'hfffffffd,
                 model_result(MUL, 32'h00000007, 32'hfffffffd));
        issue_op("after_reset_1", MULHSU, 32'hfffffff0, 32'hf0000000,
                 model_result(MULHSU, 32'hfffffff0, 32'hf0000000));
        issue_op("after_reset_2", MULH, 32'hfffffff0, 32'hf0000000,
                 model_result(MULH, 32'hfffffff0, 32'hf0000000));
        wait_drain();

        check_count("out_valid pulses", expected_pulses, out_count);
        assert_errors = i_mul_unit.i_checker.failures;
        $display("errors %0d, timeouts %0d, assertion failures %0d", errors, timeouts,
                 assert_errors);
        if (errors == 0 && timeouts == 0 && assert_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/mul_unit_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit_checker import mul_pkg::*; (
    input wire            clock,
    input wire            reset,
    input wire            in_valid,
    input wire            out_valid,
    input wire [XLEN-1:0] result
);

    int failures = 0;

    // three registered stages from strobe in to strobe out
    latency_a: assert property (@(posedge clock)
        (!reset && !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3))
        |-> (out_valid == $past(in_valid, 3)))
        else begin
            $error("out_valid does not follow in_valid by three cycles");
            failures++;
        end

    // in-flight operations are dropped
    reset_clear_a: assert property (@(posedge clock) reset |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            failures++;
        end

    result_known_a: assert property (@(posedge clock) out_valid |-> !$isunknown(result))
        else begin
            $error("result unknown while out_valid is high");
            failures++;
        end

endmodule

bind mul_unit mul_unit_checker i_checker (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result)
);

`default_nettype wire

// ==== verification/clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/mul_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit import mul_pkg::*; (
    input  wire                clock,
    input  wire                reset,
    input  wire                in_valid,
    input  wire mul_op_t       op,
    input  wire [XLEN-1:0]     rs1,
    input  wire [XLEN-1:0]     rs2,
    output logic               out_valid,
    output logic [XLEN-1:0]    result
);

    // decode to execute
    logic              dec_valid;
    logic [XLEN-1:0]   dec_x;
    logic [XLEN-1:0]   dec_y;
    logic              dec_x_signed;
    logic              dec_y_signed;
    logic              dec_high;

    // execute to result
    logic              ex_valid;
    logic [PROD_W-1:0] ex_sum;
    logic [PROD_W-1:0] ex_carry;
    logic              ex_high;

    mul_decode i_decode (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (in_valid),
        .op           (op),
        .rs1          (rs1),
        .rs2          (rs2),
        .dec_valid    (dec_valid),
        .dec_x        (dec_x),
        .dec_y        (dec_y),
        .dec_x_signed (dec_x_signed),
        .dec_y_signed (dec_y_signed),
        .dec_high     (dec_high)
    );

    mul_execute i_execute (
        .clock        (clock),
        .reset        (reset),
        .dec_valid    (dec_valid),
        .dec_x        (dec_x),
        .dec_y        (dec_y),
        .dec_x_signed (dec_x_signed),
        .dec_y_signed (dec_y_signed),
        .dec_high     (dec_high),
        .ex_valid     (ex_valid),
        .ex_sum       (ex_sum),
        .ex_carry     (ex_carry),
        .ex_high      (ex_high)
    );

    mul_result i_result (
        .clock     (clock),
        .reset     (reset),
        .ex_valid  (ex_valid),
        .ex_sum    (ex_sum),
        .ex_carry  (ex_carry),
        .ex_high   (ex_high),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== hw/mul_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_result import mul_pkg::*; (
    input  wire                clock,
    input  wire                reset,
    input  wire                ex_valid,
    input  wire [PROD_W-1:0]   ex_sum,
    input  wire [PROD_W-1:0]   ex_carry,
    input  wire                ex_high,
    output logic               out_valid,
    output logic [XLEN-1:0]    result
);

    logic [PROD_W-1:0] product;
    logic [XLEN-1:0]   word;

    // final carry propagate add, modulo 2**64
    assign product = ex_sum + ex_carry;

    // upper word for the MULH family
    assign word = ex_high ? product[PROD_W-1:XLEN] : product[XLEN-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= ex_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (ex_valid) begin
            result <= word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mul_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_execute import mul_pkg::*; (
    input  wire                clock,
    input  wire                reset,
    input  wire                dec_valid,
    input  wire [XLEN-1:0]     dec_x,
    input  wire [XLEN-1:0]     dec_y,
    input  wire                dec_x_signed,
    input  wire                dec_y_signed,
    input  wire                dec_high,
    output logic               ex_valid,
    output logic [PROD_W-1:0]  ex_sum,
    output logic [PROD_W-1:0]  ex_carry,
    output logic               ex_high
);

    pp_array_t         pp;
    logic [PROD_W-1:0] tree_sum;
    logic [PROD_W-1:0] tree_carry;

    booth_radix4 i_booth (
        .x        (dec_x),
        .y        (dec_y),
        .x_signed (dec_x_signed),
        .y_signed (dec_y_signed),
        .pp       (pp)
    );

    wallace_tree i_tree (
        .pp    (pp),
        .sum   (tree_sum),
        .carry (tree_carry)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    // product stays redundant until the result stage
    always_ff @(posedge clock) begin
        if (dec_valid) begin
            ex_sum   <= tree_sum;
            ex_carry <= tree_carry;
            ex_high  <= dec_high;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mul_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_decode import mul_pkg::*; (
    input  wire                clock,
    input  wire                reset,
    input  wire                in_valid,
    input  wire mul_op_t       op,
    input  wire [XLEN-1:0]     rs1,
    input  wire [XLEN-1:0]     rs2,
    output logic               dec_valid,
    output logic [XLEN-1:0]    dec_x,
    output logic [XLEN-1:0]    dec_y,
    output logic               dec_x_signed,
    output logic               dec_y_signed,
    output logic               dec_high
);

    logic x_signed;
    logic y_signed;

    // operand signs per operation
    always_comb begin
        x_signed = 1'b0;
        y_signed = 1'b0;
        case (op)
            MULH: begin
                x_signed = 1'b1;
                y_signed = 1'b1;
            end
            MULHSU: begin
                x_signed = 1'b1;
            end
            // MUL only keeps the low word, the same for any sign
            default: begin
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // capture operands with the strobe
    always_ff @(posedge clock) begin
        if (in_valid) begin
            dec_x        <= rs1;
            dec_y        <= rs2;
            dec_x_signed <= x_signed;
            dec_y_signed <= y_signed;
            dec_high     <= (op != MUL);
        end
    end

endmodule

`default_nettype wire

// ==== hw/wallace_tree.sv ====
`timescale 1ns/10ps
`default_nettype none

module wallace_tree import mul_pkg::*; (
    input  wire pp_array_t    pp,
    output logic [PROD_W-1:0] sum,
    output logic [PROD_W-1:0] carry
);

    logic [PROD_W-1:0] l1_sum   [4];
    logic [PROD_W-1:0] l1_carry [4];
    logic [PROD_W-1:0] l2_sum   [2];
    logic [PROD_W-1:0] l2_carry [2];
    logic [PROD_W-1:0] l3_sum;
    logic [PROD_W-1:0] l3_carry;
    logic [PROD_W-1:0] csa_b;
    logic [PROD_W-1:0] csa_maj;

    // level 1 takes the first sixteen partial products
    for (genvar i = 0; i < 4; i++) begin : g_l1
        compressor_42 i_comp (
            .a     (pp[4*i]),
            .b     (pp[4*i+1]),
            .c     (pp[4*i+2]),
            .d     (pp[4*i+3]),
            .sum   (l1_sum[i]),
            .carry (l1_carry[i])
        );
    end

    // carries move up one bit between levels
    for (genvar i = 0; i < 2; i++) begin : g_l2
        compressor_42 i_comp (
            .a     (l1_sum[2*i]),
            .b     ({l1_carry[2*i][PROD_W-2:0], 1'b0}),
            .c     (l1_sum[2*i+1]),
            .d     ({l1_carry[2*i+1][PROD_W-2:0], 1'b0}),
            .sum   (l2_sum[i]),
            .carry (l2_carry[i])
        );
    end

    compressor_42 i_comp_l3 (
        .a     (l2_sum[0]),
        .b     ({l2_carry[0][PROD_W-2:0], 1'b0}),
        .c     (l2_sum[1]),
        .d     ({l2_carry[1][PROD_W-2:0], 1'b0}),
        .sum   (l3_sum),
        .carry (l3_carry)
    );

    // 3:2 row folds in the sign extension group
    assign csa_b   = {l3_carry[PROD_W-2:0], 1'b0};
    assign sum     = l3_sum ^ csa_b ^ pp[PP_COUNT-1];
    assign csa_maj = (l3_sum & csa_b) | (csa_b & pp[PP_COUNT-1]) | (l3_sum & pp[PP_COUNT-1]);

    // carry leaves already aligned, product is sum + carry
    assign carry = {csa_maj[PROD_W-2:0], 1'b0};

endmodule

`default_nettype wire

// ==== hw/booth_radix4.sv ====
`timescale 1ns/10ps
`default_nettype none

module booth_radix4 import mul_pkg::*; (
    input  wire [XLEN-1:0] x,
    input  wire [XLEN-1:0] y,
    input  wire            x_signed,
    input  wire            y_signed,
    output pp_array_t      pp
);

    logic [PROD_W-1:0]  x_ext;
    logic [PROD_W-1:0]  x_neg;
    logic [Y_EXT_W-1:0] y_ext;

    // multiplicand widened to the full product
    assign x_ext = {{(PROD_W - XLEN){x_signed & x[XLEN-1]}}, x};
    assign x_neg = -x_ext;

    // two sign bits give the extra group for unsigned y
    assign y_ext = {{2{y_signed & y[XLEN-1]}}, y, 1'b0};

    for (genvar j = 0; j < PP_COUNT; j++) begin : g_digit
        logic [2:0]        win;
        logic              zero;
        logic              neg;
        logic              two;
        logic [PROD_W-1:0] mult;

        // overlapping three bit window of the multiplier
        assign win = y_ext[2*j +: 3];

        // digit encoder
        assign zero = (win == 3'b000) || (win == 3'b111);
        assign neg  = win[2];
        assign two  = (win == 3'b011) || (win == 3'b100);

        // pick +-1x or +-2x of the multiplicand
        always_comb begin
            if (neg) begin
                mult = two ? (x_neg << 1) : x_neg;
            end else begin
                mult = two ? (x_ext << 1) : x_ext;
            end
        end

        // each group weighs four times the previous one
        assign pp[j] = zero ? '0 : (mult << (2 * j));
    end

endmodule

`default_nettype wire

// ==== hw/compressor_42.sv ====
`timescale 1ns/10ps
`default_nettype none

module compressor_42 import mul_pkg::*; (
    input  wire [PROD_W-1:0] a,
    input  wire [PROD_W-1:0] b,
    input  wire [PROD_W-1:0] c,
    input  wire [PROD_W-1:0] d,
    output logic [PROD_W-1:0] sum,
    output logic [PROD_W-1:0] carry
);

    // majority of b, c and d per bit
    logic [PROD_W-1:0] e;
    // same term moved up to the next bit
    logic [PROD_W-1:0] e_in;
    logic [PROD_W-1:0] x4;

    assign e  = (b & c) | (c & d) | (b & d);
    assign x4 = a ^ b ^ c ^ d;

    // top bit of e falls off, the product wraps at 2**64
    assign e_in = {e[PROD_W-2:0], 1'b0};

    assign sum = x4 ^ e_in;

    // carry has weight two and is left unshifted here
    assign carry = (x4 & e_in) | (~x4 & a);

endmodule

`default_nettype wire

// ==== hw/mul_pkg.sv ====
`default_nettype none

package mul_pkg;

    // operand and result width
    localparam int XLEN = 32;

    // full product width
    localparam int PROD_W = 2 * XLEN;

    // sixteen digit groups plus one for the sign extension
    localparam int PP_COUNT = XLEN / 2 + 1;

    // multiplier with two sign bits on top and a zero below
    localparam int Y_EXT_W = XLEN + 3;

    // same order as funct3 of the RV32M multiply group
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_op_t;

    // booth partial products, index 0 is the least significant
    typedef logic [PP_COUNT-1:0][PROD_W-1:0] pp_array_t;

endpackage

`default_nettype wire
